/* hdl/cpu_pkg.sv */
package cpu_pkg;

    ////////////////////////////////////////
    // widths and base types
    ////////////////////////////////////////
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       instr_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [XLEN-1:0]       word_t;

    // op_nop first so a cleared bundle is a bubble
    typedef enum logic [2:0] {
        op_nop   = 3'd0,
        op_add   = 3'd1,
        op_sub   = 3'd2,
        op_and   = 3'd3,
        op_or    = 3'd4,
        op_xor   = 3'd5,
        op_lu12i = 3'd6
    } alu_op_e;

    ////////////////////////////////////////
    // opcode match values, upper word bits
    ////////////////////////////////////////
    localparam logic [16:0] OPC_ADD_W   = 17'h00020;  // 3R format, bits 31:15
    localparam logic [16:0] OPC_SUB_W   = 17'h00022;
    localparam logic [16:0] OPC_AND     = 17'h00029;
    localparam logic [16:0] OPC_OR      = 17'h0002a;
    localparam logic [16:0] OPC_XOR     = 17'h0002b;
    localparam logic [9:0]  OPC_ADDI_W  = 10'h00a;    // 2RI12, bits 31:22
    localparam logic [6:0]  OPC_LU12I_W = 7'h0a;      // 1RI20, bits 31:25

    // field positions
    localparam int OPC17_LSB = 15;
    localparam int OPC10_LSB = 22;
    localparam int OPC7_LSB  = 25;
    localparam int RD_LSB    = 0;
    localparam int RJ_LSB    = 5;
    localparam int RK_LSB    = 10;
    localparam int SI12_LSB  = 10;
    localparam int SI12_W    = 12;
    localparam int SI20_LSB  = 5;
    localparam int SI20_W    = 20;

    ////////////////////////////////////////
    // stage bundles
    ////////////////////////////////////////
    typedef struct packed {
        logic      valid;
        alu_op_e   op;
        reg_addr_t rj;
        reg_addr_t rk;
        logic      use_imm;
        word_t     imm;
        reg_addr_t rd;
        logic      wen;      // low for r0 targets and unknown words
    } decoded_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

endpackage

/* hdl/alu.sv */
module alu import cpu_pkg::*; (
    input  alu_op_e i_op,
    input  word_t   i_src_a,
    input  word_t   i_src_b,
    output word_t   o_result
);

    always_comb begin
        case (i_op)
            op_add: begin
                o_result = i_src_a + i_src_b;  // wraps at 32 bits
            end
            op_sub: begin
                o_result = i_src_a - i_src_b;
            end
            op_and: begin
                o_result = i_src_a & i_src_b;
            end
            op_or: begin
                o_result = i_src_a | i_src_b;
            end
            op_xor: begin
                o_result = i_src_a ^ i_src_b;
            end
            op_lu12i: begin
                // immediate already shifted by the decoder
                o_result = i_src_b;
            end
            default: begin
                o_result = '0;
            end
        endcase
    end

endmodule

/* hdl/reg_file.sv */
module reg_file import cpu_pkg::*; (
    input  logic      clk,
    input  logic      i_rst_n,
    input  reg_addr_t i_raddr_a,
    input  reg_addr_t i_raddr_b,
    output word_t     o_rdata_a,
    output word_t     o_rdata_b,
    input  wb_t       i_wb
);

    localparam int NUM_REGS = 1 << REG_ADDR_W;

    word_t regs [NUM_REGS];

    // all registers come out of reset as zero
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb.valid && (i_wb.rd != '0)) begin
            regs[i_wb.rd] <= i_wb.data;
        end
    end

    ////////////////////////////////////////
    // async read, r0 hardwired
    ////////////////////////////////////////
    assign o_rdata_a = (i_raddr_a == '0) ? '0 : regs[i_raddr_a];
    assign o_rdata_b = (i_raddr_b == '0) ? '0 : regs[i_raddr_b];

endmodule

/* hdl/instr_decoder.sv */
module instr_decoder import cpu_pkg::*; (
    input  logic     clk,
    input  logic     i_rst_n,
    input  logic     i_instr_valid,
    input  instr_t   i_instr,
    output decoded_t o_dec
);

    logic [16:0]       opc17;
    logic [9:0]        opc10;
    logic [6:0]        opc7;
    logic [SI12_W-1:0] si12;
    logic [SI20_W-1:0] si20;
    reg_addr_t         rd;
    decoded_t          dec_next;

    ////////////////////////////////////////
    // field slicing
    ////////////////////////////////////////
    assign opc17 = i_instr[XLEN-1:OPC17_LSB];
    assign opc10 = i_instr[XLEN-1:OPC10_LSB];
    assign opc7  = i_instr[XLEN-1:OPC7_LSB];
    assign si12  = i_instr[SI12_LSB +: SI12_W];
    assign si20  = i_instr[SI20_LSB +: SI20_W];
    assign rd    = i_instr[RD_LSB +: REG_ADDR_W];

    always_comb begin
        dec_next         = '0;
        dec_next.valid   = i_instr_valid;
        dec_next.rj      = i_instr[RJ_LSB +: REG_ADDR_W];
        dec_next.rk      = i_instr[RK_LSB +: REG_ADDR_W];
        dec_next.rd      = rd;
        dec_next.op      = op_nop;  // anything unmatched stays a bubble

        if (opc17 == OPC_ADD_W) begin
            dec_next.op = op_add;
        end else if (opc17 == OPC_SUB_W) begin
            dec_next.op = op_sub;
        end else if (opc17 == OPC_AND) begin
            dec_next.op = op_and;
        end else if (opc17 == OPC_OR) begin
            dec_next.op = op_or;
        end else if (opc17 == OPC_XOR) begin
            dec_next.op = op_xor;
        end else if (opc10 == OPC_ADDI_W) begin
            dec_next.op      = op_add;
            dec_next.use_imm = 1'b1;
            dec_next.imm     = {{(XLEN-SI12_W){si12[SI12_W-1]}}, si12};  // sign extend
        end else if (opc7 == OPC_LU12I_W) begin
            dec_next.op      = op_lu12i;
            dec_next.use_imm = 1'b1;
            dec_next.imm     = {si20, {(XLEN-SI20_W){1'b0}}};
        end

        dec_next.wen = i_instr_valid && (rd != '0) && (dec_next.op != op_nop);
    end

    // decode register, one word per strobe
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_dec <= '0;
        end else begin
            o_dec <= dec_next;
        end
    end

    // a write enable always comes with a real target and a real op
    a_wen_target: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_dec.wen |-> o_dec.valid && (o_dec.rd != '0) && (o_dec.op != op_nop));

endmodule

/* hdl/exec_stage.sv */
module exec_stage import cpu_pkg::*; (
    input  logic      clk,
    input  logic      i_rst_n,
    input  decoded_t  i_dec,
    output reg_addr_t o_raddr_a,
    output reg_addr_t o_raddr_b,
    input  word_t     i_rdata_a,
    input  word_t     i_rdata_b,
    output wb_t       o_wb
);

    logic  fwd_a;
    logic  fwd_b;
    word_t src_a;
    word_t rk_val;
    word_t src_b;
    word_t alu_result;

    ////////////////////////////////////////
    // operand read
    ////////////////////////////////////////
    assign o_raddr_a = i_dec.rj;
    assign o_raddr_b = i_dec.rk;

    // writeback register not yet in the file, take it from here
    assign fwd_a = o_wb.valid && (o_wb.rd == i_dec.rj);
    assign fwd_b = o_wb.valid && (o_wb.rd == i_dec.rk);

    assign src_a  = fwd_a ? o_wb.data : i_rdata_a;
    assign rk_val = fwd_b ? o_wb.data : i_rdata_b;
    assign src_b  = i_dec.use_imm ? i_dec.imm : rk_val;  // addi.w and lu12i.w

    alu alu_inst (
        .i_op(i_dec.op),
        .i_src_a(src_a),
        .i_src_b(src_b),
        .o_result(alu_result)
    );

    ////////////////////////////////////////
    // writeback register
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb <= '0;
        end else begin
            o_wb.valid <= i_dec.valid && i_dec.wen;
            o_wb.rd    <= i_dec.rd;
            o_wb.data  <= alu_result;
        end
    end

    // r0 never reaches the write port, so bypass never forwards into r0
    a_wb_rd_nonzero: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_wb.valid |-> (o_wb.rd != '0));

endmodule

/* hdl/cpu_core.sv */
module cpu_core import cpu_pkg::*; (
    input  logic   clk,
    input  logic   i_rst_n,
    input  logic   i_instr_valid,
    input  instr_t i_instr,
    output wb_t    o_wb
);

    decoded_t  id_ex;
    reg_addr_t raddr_a;
    reg_addr_t raddr_b;
    word_t     rdata_a;
    word_t     rdata_b;

    ////////////////////////////////////////
    // decode stage
    ////////////////////////////////////////
    instr_decoder instr_decoder_inst (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_instr_valid(i_instr_valid),
        .i_instr(i_instr),
        .o_dec(id_ex)
    );

    ////////////////////////////////////////
    // execute and writeback
    ////////////////////////////////////////
    exec_stage exec_stage_inst (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_dec(id_ex),
        .o_raddr_a(raddr_a),
        .o_raddr_b(raddr_b),
        .i_rdata_a(rdata_a),
        .i_rdata_b(rdata_b),
        .o_wb(o_wb)
    );

    reg_file reg_file_inst (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_raddr_a(raddr_a),
        .i_raddr_b(raddr_b),
        .o_rdata_a(rdata_a),
        .o_rdata_b(rdata_b),
        .i_wb(o_wb)         // same bundle as the debug port
    );

endmodule

/* verif/tb_cpu_core.sv */
module tb_cpu_core import cpu_pkg::*; ();

    localparam int DRAIN_LIMIT = 50;  // cycles allowed to empty the queue

    logic   clk;
    logic   i_rst_n;
    logic   i_instr_valid;
    instr_t i_instr;
    wb_t    o_wb;

    int  seed      = 87;
    int  cycle_cnt = 0;
    wb_t exp_q [$];  // expected writebacks in program order
    int  cyc_q [$];  // strobe cycle of each queued entry

    cpu_core i_dut (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_instr_valid(i_instr_valid),
        .i_instr(i_instr),
        .o_wb(o_wb)
    );

    ////////////////////////////////////////
    // clock and cycle count
    ////////////////////////////////////////
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        forever begin
            @(posedge clk);
            cycle_cnt = cycle_cnt + 1;
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////
    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("ERROR @%0t: %s is %08h, expected %08h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_wb(input wb_t got, input wb_t exp, input string what);
        if (got !== exp) begin
            $display("ERROR @%0t: %s got v=%0b rd=%0d d=%08h, expected v=%0b rd=%0d d=%08h",
                     $time, what, got.valid, got.rd, got.data, exp.valid, exp.rd, exp.data);
            abort_run();
        end
    endtask

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////
    task automatic drive_word(input instr_t word, input int gap);
        repeat (gap) begin
            @(negedge clk);
            i_instr_valid = 1'b0;
            i_instr       = {$random(seed)};  // junk, no strobe
        end
        @(negedge clk);
        i_instr_valid = 1'b1;
        i_instr       = word;
    endtask

    task automatic run_program();
        int          fd;
        int          n;
        int          gap;
        string       line;
        instr_t      word;
        logic [31:0] flag;
        logic [31:0] rd_val;
        word_t       data_val;
        wb_t         exp_wb;
        reg_addr_t   last_rd;
        logic        have_last;

        have_last = 1'b0;
        last_rd   = '0;
        fd = $fopen("verif/cpu_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file verif/cpu_testdata.txt");
            abort_run();
        end
        while ($fgets(line, fd) != 0) begin
            if (line.getc(0) == "#" || line.getc(0) == "\n") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h", word, flag, rd_val, data_val);
            if (n != 4 || rd_val > 31) begin
                $display("malformed line in the stimulus file: %s", line);
                abort_run();
            end
            gap = {$random(seed)} % 3;
            // consumer of the last result goes right behind it, hits the bypass
            if (have_last && (word[9:5] == last_rd || word[14:10] == last_rd)) begin
                gap = 0;
            end
            drive_word(word, gap);
            if (flag != 0) begin
                exp_wb.valid = 1'b1;
                exp_wb.rd    = rd_val[4:0];
                exp_wb.data  = data_val;
                exp_q.push_back(exp_wb);
                cyc_q.push_back(cycle_cnt);
                last_rd   = rd_val[4:0];
                have_last = 1'b1;
            end
        end
        $fclose(fd);
        @(negedge clk);
        i_instr_valid = 1'b0;
        i_instr       = '0;
    endtask

    ////////////////////////////////////////
    // writeback monitor
    ////////////////////////////////////////
    initial begin
        wb_t exp_wb;
        int  strobe_cyc;

        forever begin
            @(negedge clk);
            if (o_wb.valid) begin
                if (exp_q.size() == 0) begin
                    $display("unexpected writeback strobe for r%0d at time %0t",
                             o_wb.rd, $time);
                    abort_run();
                end else begin
                    exp_wb     = exp_q.pop_front();
                    strobe_cyc = cyc_q.pop_front();
                    if (cycle_cnt - strobe_cyc != 2) begin
                        $display("ERROR @%0t: r%0d written %0d cycles after its strobe",
                                 $time, o_wb.rd, cycle_cnt - strobe_cyc);
                        abort_run();
                    end
                    check_word(o_wb.data, exp_wb.data, "writeback data");
                    check_wb(o_wb, exp_wb, "writeback bundle");
                end
            end else if (exp_q.size() != 0 && cycle_cnt - cyc_q[0] >= 2) begin
                $display("ERROR @%0t: writeback to r%0d missing two cycles after strobe",
                         $time, exp_q[0].rd);
                abort_run();
            end
        end
    end

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial begin
        int waited;

        i_rst_n       = 1'b0;
        i_instr_valid = 1'b0;
        i_instr       = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1'b1;

        // port stays quiet until the first strobe
        repeat (3) begin
            @(negedge clk);
            check_wb(o_wb, '0, "writeback port after reset");
        end

        run_program();

        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited = waited + 1;
        end
        repeat (4) @(negedge clk);  // room for a stray strobe
        if (exp_q.size() == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("timed out with %0d writebacks still outstanding", exp_q.size());
            abort_run();
        end
    end

endmodule

/* verif/cpu_testdata.txt */
# columns in hex: instruction word, expect flag, expected rd, expected data
# an expect flag of 0 means the word must not produce a writeback
02801401 1 01 00000005
029ffc03 1 03 000007ff
02a00004 1 04 fffff800
02bffc02 1 02 ffffffff
00100825 1 05 00000004
00110c26 1 06 fffff806
00110407 1 07 fffffffb
142468a8 1 08 12345000
15ffffe9 1 09 fffff000
0299e108 1 08 12345678
0014a50a 1 0a 12345000
0015054b 1 0b 12345005
0015896c 1 0c edcbaffa
02819020 0 00 00000000
ffffffff 0 00 00000000
0010000d 1 0d 00000000
0010300e 1 0e edcbaffa
028005ef 1 0f 00000001
028005ef 1 0f 00000002
028005ef 1 0f 00000003
001115f0 1 10 ffffffff
02bfc21f 1 1f ffffffef
0015fff1 1 11 00000000
00151cd2 1 12 ffffffff
15579bd3 1 13 abcde000
00000000 0 00 00000000
00104e74 1 14 579bc000

/* sim.f */
hdl/cpu_pkg.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/instr_decoder.sv
hdl/exec_stage.sv
hdl/cpu_core.sv
verif/tb_cpu_core.sv

/* Makefile */
TOP := tb_cpu_core

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f sim.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
